// File: Makefile
TOOL     = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = tb_mt_core
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

# the memory image is loaded from the working directory, so the run starts in tests/
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	cd tests && ../obj_dir/V$(TOP) +verilator+error+limit+1000 > ../$(LOG) 2>&1; true
	cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: rtl/code_memory.sv
module code_memory import mt_core_pkg::*; (
    input  logic clk,
    input  logic hold,
    ibus_if.mem  ibus,
    dbus_if.mem  dbus
);

    rval_t     mem [2**MEM_ADDR_BITS];
    mem_addr_t iaddr;
    mem_addr_t daddr;
    rval_t     i_st0;
    rval_t     d_st0;
    id_t       id_st0;
    pc_t       pc_st0;
    logic      iv_st0;
    logic      dv_st0;

    initial $readmemh("prog.hex", mem);

    assign iaddr = ibus.pc[MEM_ADDR_BITS+1:2];
    assign daddr = dbus.addr[MEM_ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        if (!hold) begin
            // fetch port, word and tag move together
            i_st0 <= mem[iaddr];
            id_st0 <= ibus.id;
            pc_st0 <= ibus.pc;
            iv_st0 <= ibus.valid;
            ibus.instr <= i_st0;
            ibus.res_id <= id_st0;
            ibus.res_pc <= pc_st0;
            ibus.res_valid <= iv_st0;
            // data port
            d_st0 <= mem[daddr];
            dv_st0 <= dbus.valid && !dbus.wr;
            dbus.rdata <= d_st0;
            dbus.rvalid <= dv_st0;
            for (int b = 0; b < XLEN / 8; b++) begin
                if (dbus.valid && dbus.wr && dbus.strb[b]) begin
                    mem[daddr][8*b +: 8] <= dbus.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: rtl/core_bus_if.sv
interface ibus_if import mt_core_pkg::*; ();
    // fetch command
    id_t    id;
    pc_t    pc;
    logic   valid;
    // tag delayed alongside the fetched word
    id_t    res_id;
    pc_t    res_pc;
    logic   res_valid;
    instr_t instr;

    modport cmd (output id, pc, valid);
    modport mem (input id, pc, valid, output res_id, res_pc, res_valid, instr);
    modport res (input res_id, res_pc, res_valid, instr);
endinterface

interface dbus_if import mt_core_pkg::*; ();
    rval_t addr;
    logic  wr;
    strb_t strb;
    rval_t wdata;
    logic  valid;
    rval_t rdata;
    logic  rvalid;

    modport cmd (output addr, wr, strb, wdata, valid);
    modport mem (input addr, wr, strb, wdata, valid, output rdata, rvalid);
    // result side also sees the address for the output port
    modport res (input addr, rdata, rvalid);
endinterface

// File: rtl/execute_unit.sv
module execute_unit import mt_core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  hold,
    input  logic  dec_valid,
    input  id_t   dec_id,
    input  pc_t   dec_pc,
    input  op_e   dec_op,
    input  ridx_t dec_rd,
    input  ridx_t dec_rs1,
    input  ridx_t dec_rs2,
    input  rval_t dec_imm,
    dbus_if.cmd   dbus,
    output logic  redirect_valid,
    output id_t   redirect_id,
    output pc_t   redirect_pc,
    output logic  redirect_halt,
    input  logic  wb_valid,
    input  id_t   wb_id,
    input  ridx_t wb_rd,
    input  rval_t wb_value,
    output logic  ex_valid,
    output id_t   ex_id,
    output ridx_t ex_rd,
    output rval_t ex_value,
    output logic  ex_load,
    output logic  ex_mmio
);

    // one bank of 32 registers per thread
    rval_t regs [THREADS][32];
    rval_t rs1_val;
    rval_t rs2_val;
    rval_t addr;
    rval_t result;
    pc_t   next_pc;
    logic  writes_rd;
    logic  is_mmio;

    always_ff @(posedge clk) begin
        if (!hold && wb_valid) begin
            regs[wb_id][wb_rd] <= wb_value;
        end
    end

    assign rs1_val = (dec_rs1 == '0) ? '0 : regs[dec_id][dec_rs1];
    assign rs2_val = (dec_rs2 == '0) ? '0 : regs[dec_id][dec_rs2];
    assign addr = rs1_val + dec_imm;
    assign is_mmio = (dec_op == OP_SW) && (addr[31:24] == MMIO_BASE);

    always_comb begin
        result = '0;
        next_pc = dec_pc + pc_t'(4);
        writes_rd = 1'b1;
        case (dec_op)
            OP_ADDI: result = addr;
            OP_ADD:  result = rs1_val + rs2_val;
            OP_SUB:  result = rs1_val - rs2_val;
            OP_LUI:  result = dec_imm;
            OP_LW:   result = '0;
            OP_JAL: begin
                result = dec_pc + pc_t'(4);
                next_pc = dec_pc + pc_t'(dec_imm);
            end
            OP_BNE: begin
                writes_rd = 1'b0;
                if (rs1_val != rs2_val) next_pc = dec_pc + pc_t'(dec_imm);
            end
            OP_SW: begin
                // store data rides along for the output port
                writes_rd = 1'b0;
                result = rs2_val;
            end
            default: writes_rd = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_valid <= 1'b0;
            ex_valid <= 1'b0;
            dbus.valid <= 1'b0;
        end else if (!hold) begin
            // loads report back through load_done instead
            redirect_valid <= dec_valid && (dec_op != OP_LW);
            redirect_id <= dec_id;
            redirect_pc <= next_pc;
            redirect_halt <= (dec_op == OP_JAL) && (dec_imm == j_imm(HALT));
            ex_valid <= dec_valid;
            ex_id <= dec_id;
            ex_rd <= writes_rd ? dec_rd : '0;
            ex_value <= result;
            ex_load <= dec_op == OP_LW;
            ex_mmio <= dec_valid && is_mmio;
            dbus.valid <= dec_valid && ((dec_op == OP_LW) || (dec_op == OP_SW && !is_mmio));
            dbus.wr <= dec_op == OP_SW;
            dbus.strb <= (dec_op == OP_SW) ? '1 : '0;
            dbus.addr <= addr;
            dbus.wdata <= rs2_val;
        end
    end

endmodule

// File: rtl/instr_decode.sv
module instr_decode import mt_core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  hold,
    ibus_if.res   ibus,
    output logic  dec_valid,
    output id_t   dec_id,
    output pc_t   dec_pc,
    output op_e   dec_op,
    output ridx_t dec_rd,
    output ridx_t dec_rs1,
    output ridx_t dec_rs2,
    output rval_t dec_imm
);

    op_e   op;
    rval_t imm;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = ibus.instr[14:12];
    assign funct7 = ibus.instr[31:25];

    always_comb begin
        op = OP_NOP;
        // I-type unless the opcode says otherwise
        imm = {{20{ibus.instr[31]}}, ibus.instr[31:20]};
        case (ibus.instr[6:0])
            OPC_OP_IMM: if (funct3 == 3'b000) op = OP_ADDI;
            OPC_OP: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) op = OP_ADD;
                else if (funct3 == 3'b000 && funct7 == 7'b0100000) op = OP_SUB;
            end
            OPC_LUI: begin
                op = OP_LUI;
                imm = {ibus.instr[31:12], 12'b0};
            end
            OPC_LOAD: if (funct3 == 3'b010) op = OP_LW;
            OPC_STORE: begin
                if (funct3 == 3'b010) op = OP_SW;
                imm = {{20{ibus.instr[31]}}, ibus.instr[31:25], ibus.instr[11:7]};
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b001) op = OP_BNE;
                imm = {{20{ibus.instr[31]}}, ibus.instr[7], ibus.instr[30:25],
                       ibus.instr[11:8], 1'b0};
            end
            OPC_JAL: begin
                op = OP_JAL;
                imm = j_imm(ibus.instr);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (!hold) begin
            dec_valid <= ibus.res_valid;
            dec_id <= ibus.res_id;
            dec_pc <= ibus.res_pc;
            dec_op <= op;
            dec_rd <= ibus.instr[11:7];
            dec_rs1 <= ibus.instr[19:15];
            dec_rs2 <= ibus.instr[24:20];
            dec_imm <= imm;
        end
    end

endmodule

// File: rtl/mt_core_pkg.sv
package mt_core_pkg;

    localparam int XLEN          = 32;
    localparam int THREADS       = 4;
    localparam int MEM_ADDR_BITS = 10;

    typedef logic [$clog2(THREADS)-1:0] id_t;
    typedef logic [31:0]                pc_t;
    typedef logic [31:0]                instr_t;
    typedef logic [XLEN-1:0]            rval_t;
    typedef logic [4:0]                 ridx_t;
    typedef logic [MEM_ADDR_BITS-1:0]   mem_addr_t;
    typedef logic [XLEN/8-1:0]          strb_t;

    typedef enum logic [3:0] {
        OP_ADDI, OP_ADD, OP_SUB, OP_LUI, OP_LW, OP_SW, OP_BNE, OP_JAL, OP_NOP
    } op_e;

    typedef enum logic [1:0] {IDLE, BUSY, HALTED} thread_state_e;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam pc_t INIT_PC [THREADS] = '{32'h000, 32'h040, 32'h080, 32'h0c0};

    // top byte of a data address that selects the output port
    localparam logic [7:0] MMIO_BASE = 8'hf0;

    // jal x0, 0
    localparam instr_t HALT = 32'h0000006f;

    function automatic rval_t j_imm(instr_t w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

endpackage

// File: rtl/mt_core_top.sv
module mt_core_top import mt_core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       out_wait,
    output logic       out_valid,
    output id_t        out_id,
    output logic [7:0] out_addr,
    output rval_t      out_data
);

    logic  hold;
    logic  redirect_valid, redirect_halt;
    id_t   redirect_id;
    pc_t   redirect_pc;
    logic  load_done;
    id_t   load_id;
    logic  dec_valid;
    id_t   dec_id;
    pc_t   dec_pc;
    op_e   dec_op;
    ridx_t dec_rd, dec_rs1, dec_rs2;
    rval_t dec_imm;
    logic  ex_valid, ex_load, ex_mmio;
    id_t   ex_id;
    ridx_t ex_rd;
    rval_t ex_value;
    logic  wb_valid;
    id_t   wb_id;
    ridx_t wb_rd;
    rval_t wb_value;

    ibus_if ibus ();
    dbus_if dbus ();

    thread_fetch thread_fetch_i (.*);
    instr_decode instr_decode_i (.*);
    execute_unit execute_unit_i (.*);
    result_writeback result_writeback_i (.*);
    code_memory code_memory_i (.clk, .hold, .ibus, .dbus);

endmodule

// File: rtl/result_writeback.sv
module result_writeback import mt_core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output logic       hold,
    input  logic       ex_valid,
    input  id_t        ex_id,
    input  ridx_t      ex_rd,
    input  rval_t      ex_value,
    input  logic       ex_load,
    input  logic       ex_mmio,
    dbus_if.res        dbus,
    output logic       wb_valid,
    output id_t        wb_id,
    output ridx_t      wb_rd,
    output rval_t      wb_value,
    output logic       load_done,
    output id_t        load_id,
    input  logic       out_wait,
    output logic       out_valid,
    output id_t        out_id,
    output logic [7:0] out_addr,
    output rval_t      out_data
);

    // tag pipeline lines up with the two-cycle load latency
    logic  s1_valid, s2_valid;
    logic  s1_load, s2_load;
    id_t   s1_id, s2_id;
    ridx_t s1_rd, s2_rd;
    rval_t s1_value, s2_value;

    assign hold = out_valid && out_wait;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            wb_valid <= 1'b0;
            load_done <= 1'b0;
            out_valid <= 1'b0;
        end else if (!hold) begin
            s1_valid <= ex_valid && !ex_mmio;
            s1_load <= ex_load;
            s1_id <= ex_id;
            s1_rd <= ex_rd;
            s1_value <= ex_value;
            s2_valid <= s1_valid;
            s2_load <= s1_load;
            s2_id <= s1_id;
            s2_rd <= s1_rd;
            s2_value <= s1_value;
            // all writes land on the same slot, so loads never collide with alu results
            wb_valid <= s2_valid && (s2_rd != '0) && (!s2_load || dbus.rvalid);
            wb_id <= s2_id;
            wb_rd <= s2_rd;
            wb_value <= s2_load ? dbus.rdata : s2_value;
            load_done <= s2_valid && s2_load && dbus.rvalid;
            load_id <= s2_id;
            out_valid <= ex_valid && ex_mmio;
            out_id <= ex_id;
            out_addr <= dbus.addr[7:0];
            out_data <= ex_value;
        end
    end

endmodule

// File: rtl/thread_fetch.sv
module thread_fetch import mt_core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  hold,
    ibus_if.cmd   ibus,
    input  logic  redirect_valid,
    input  id_t   redirect_id,
    input  pc_t   redirect_pc,
    input  logic  redirect_halt,
    input  logic  load_done,
    input  id_t   load_id
);

    thread_state_e state [THREADS];
    pc_t           pc_q [THREADS];
    id_t           last_id;
    logic          pick_valid;
    id_t           pick_id;

    // first idle thread after the one issued last
    always_comb begin
        id_t cand;
        pick_valid = 1'b0;
        pick_id = last_id;
        for (int i = 1; i <= THREADS; i++) begin
            cand = last_id + id_t'(i);
            if (!pick_valid && state[cand] == IDLE) begin
                pick_valid = 1'b1;
                pick_id = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int t = 0; t < THREADS; t++) begin
                state[t] <= IDLE;
                pc_q[t] <= INIT_PC[t];
            end
            last_id <= id_t'(THREADS - 1);
            ibus.valid <= 1'b0;
        end else if (!hold) begin
            ibus.valid <= pick_valid;
            ibus.id <= pick_id;
            ibus.pc <= pc_q[pick_id];
            if (pick_valid) begin
                state[pick_id] <= BUSY;
                last_id <= pick_id;
            end
            if (redirect_valid) begin
                pc_q[redirect_id] <= redirect_pc;
                state[redirect_id] <= redirect_halt ? HALTED : IDLE;
            end
            // loads resolve late, pc simply steps on
            if (load_done) begin
                pc_q[load_id] <= pc_q[load_id] + pc_t'(4);
                state[load_id] <= IDLE;
            end
        end
    end

endmodule

// File: sim.f
rtl/mt_core_pkg.sv
rtl/core_bus_if.sv
rtl/thread_fetch.sv
rtl/instr_decode.sv
rtl/execute_unit.sv
rtl/result_writeback.sv
rtl/code_memory.sv
rtl/mt_core_top.sv
tests/mt_core_props.sv
tests/tb_mt_core.sv

// File: tests/mt_core_props.sv
module mt_core_props import mt_core_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       hold,
    input logic       out_wait,
    input logic       out_valid,
    input id_t        out_id,
    input logic [7:0] out_addr,
    input rval_t      out_data,
    input logic       issue_valid,
    input id_t        issue_id
);

    int fail_count = 0;

    // nothing on the output port while reset is held
    assert property (@(posedge clk) $past(reset) |-> !out_valid)
        else begin
            $error("out_valid high during reset");
            fail_count++;
        end

    // a stalled write keeps its id, address and data
    assert property (@(posedge clk) disable iff (reset)
        out_valid && out_wait |=> out_valid && $stable(out_id) && $stable(out_addr)
            && $stable(out_data))
        else begin
            $error("output port changed while out_wait was high");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !$isunknown(out_id) && int'(out_id) < THREADS)
        else begin
            $error("out_id outside the thread range");
            fail_count++;
        end

    // a busy thread is never issued twice in a row
    assert property (@(posedge clk) disable iff (reset)
        issue_valid && !hold |=> !issue_valid || issue_id != $past(issue_id))
        else begin
            $error("same thread issued on back-to-back cycles");
            fail_count++;
        end

endmodule

bind mt_core_top mt_core_props props_i (.*, .issue_valid(ibus.valid), .issue_id(ibus.id));

// File: tests/prog.hex
// word address lines, then instruction words in program order
// start slots jump to each thread's routine
@0 1000006f
@10 1400006f
@20 1800006f
@30 1c00006f
// thread 0, sum to 5, data word at byte 0x400
@40 f00000b7 00500113 00000193 002181b3 fff10113 fe011ce3 0030a023 06400213
@48 40402023 40002283 00000313 406282b3 0050a0a3 123453b7 00038393 0070a123 0000006f
// thread 1, sum to 10, data word at byte 0x404
@60 f00000b7 00a00113 00000193 002181b3 fff10113 fe011ce3 0030a023 06500213
@68 40402223 40402283 00100313 406282b3 0050a0a3 123453b7 00138393 0070a123 0000006f
// thread 2, sum to 15, data word at byte 0x408
@80 f00000b7 00f00113 00000193 002181b3 fff10113 fe011ce3 0030a023 06600213
@88 40402423 40802283 00200313 406282b3 0050a0a3 123453b7 00238393 0070a123 0000006f
// thread 3, sum to 20, data word at byte 0x40c
@a0 f00000b7 01400113 00000193 002181b3 fff10113 fe011ce3 0030a023 06700213
@a8 40402623 40c02283 00300313 406282b3 0050a0a3 123453b7 00338393 0070a123 0000006f

// File: tests/tb_mt_core.sv
module tb_mt_core import mt_core_pkg::*; ();

    logic       clk;
    logic       reset;
    logic       out_wait;
    logic       out_valid;
    id_t        out_id;
    logic [7:0] out_addr;
    rval_t      out_data;

    rval_t expected [THREADS][3];
    int    got [THREADS];
    int    err_test [7];
    int    accepted;
    int    active;
    int    last_active;
    int    stalls;

    mt_core_top mt_core_top_i (.*);

    // sum of 1 to n, as the loop in each routine builds it
    function automatic rval_t sum_to(int n);
        rval_t s;
        s = '0;
        for (int i = 1; i <= n; i++) begin
            s += rval_t'(i);
        end
        return s;
    endfunction

    // lower bound on the cycles to the last write with one instruction in flight core-wide
    function automatic int serial_cycles();
        int n;
        n = 0;
        for (int t = 0; t < THREADS; t++) begin
            // jal, lui, two addi, three per loop pass, nine more before the last store
            n += 3 * 5 * (t + 1) + 13;
        end
        // a thread is eligible again five cycles after its issue at the earliest
        return 5 * n;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // back-pressure on roughly one cycle in three
    initial begin
        void'($urandom(24));
        out_wait = 1'b0;
        forever begin
            @(posedge clk);
            out_wait <= reset ? 1'b0 : ($urandom % 3 == 0);
        end
    end

    always @(posedge clk) begin
        int k;
        id_t id;
        // cycles in which the core moves on, and cycles held by the output port
        if (!reset && out_valid && out_wait) begin
            stalls++;
        end else if (!reset) begin
            active++;
        end
        if (!reset && out_valid && !out_wait) begin
            id = out_id;
            k = got[id];
            assert (k < 3)
                else begin
                    $display("extra write from thread %0d at time %0t", id, $time);
                    err_test[5]++;
                end
            if (k < 3) begin
                assert (out_addr == 8'(k))
                    else begin
                        $display("ERROR %0t out_addr exp %0d got %0d", $time, k, out_addr);
                        err_test[5]++;
                    end
                // store k of a routine belongs to test k+2
                assert (out_data == expected[id][k])
                    else begin
                        $display("ERROR %0t out_data exp %h got %h", $time,
                                 expected[id][k], out_data);
                        err_test[k + 2]++;
                    end
            end
            got[id]++;
            accepted++;
            last_active = active;
        end
    end

    initial begin
        int cycles;
        int total;
        int bound;
        reset = 1'b1;
        accepted = 0;
        active = 0;
        last_active = 0;
        stalls = 0;
        for (int t = 0; t < THREADS; t++) begin
            got[t] = 0;
            expected[t][0] = sum_to(5 * (t + 1));
            expected[t][1] = rval_t'(100);
            expected[t][2] = 32'h12345000 + rval_t'(t);
        end
        for (int i = 0; i < 7; i++) err_test[i] = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        cycles = 0;
        while (accepted < 3 * THREADS && cycles < 5000) begin
            @(posedge clk);
            cycles++;
        end
        if (accepted < 3 * THREADS) begin
            $display("timeout: only %0d of %0d output writes arrived", accepted, 3 * THREADS);
            $display("TESTBENCH FAILED");
            $finish;
        end
        // late duplicates would show up here
        cycles = 0;
        while (cycles < 100) begin
            @(posedge clk);
            cycles++;
        end

        assert (stalls > 0)
            else begin
                $display("back-pressure never held a write on the output port");
                err_test[5]++;
            end
        for (int t = 0; t < THREADS; t++) begin
            assert (got[t] == 3)
                else begin
                    $display("thread %0d made %0d writes instead of 3", t, got[t]);
                    err_test[6]++;
                end
        end
        bound = serial_cycles();
        assert (last_active < bound)
            else begin
                $display("last write after %0d cycles, not faster than one thread at a time (%0d)",
                         last_active, bound);
                err_test[6]++;
            end

        $display("test 1 reset: %0d assertion errors", mt_core_top_i.props_i.fail_count);
        $display("test 2 loop arithmetic: %0d errors", err_test[2]);
        $display("test 3 memory round trip: %0d errors", err_test[3]);
        $display("test 4 lui and immediates: %0d errors", err_test[4]);
        $display("test 5 back-pressure and order: %0d errors", err_test[5]);
        $display("test 6 threading: %0d errors", err_test[6]);
        total = mt_core_top_i.props_i.fail_count;
        for (int i = 2; i < 7; i++) total += err_test[i];
        $display("tests run: 6, writes: %0d, errors: %0d", accepted, total);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
